// File: common/input_pkg.sv
package input_pkg;

    localparam int BUTTONS = 2;
    localparam int BOARD_W = 16;
    localparam int JOY_W   = 8 + BUTTONS;   // dirs, buttons, start, coin, pause
    localparam int PLAYER_W = 4;
    localparam int DIR_W   = 4;
    localparam int FIRE_W  = 3;

    // direction bits, same order on board and game words
    localparam int DIR_RIGHT = 0;
    localparam int DIR_LEFT  = 1;
    localparam int DIR_DOWN  = 2;
    localparam int DIR_UP    = 3;

    localparam int BUT1_BIT  = 4;
    localparam int START_BIT = 4 + BUTTONS;
    localparam int COIN_BIT  = 5 + BUTTONS;
    localparam int PAUSE_BIT = 6 + BUTTONS;

    localparam bit ACTIVE_LOW = 1'b1;       // game side sees inverted inputs

    // button 1 passes on the last frames of each 8-frame period
    localparam logic [FIRE_W-1:0] AUTOFIRE_ON = 3'd6;

    typedef logic [BOARD_W-1:0]  board_joy_t;
    typedef logic [JOY_W-1:0]    game_joy_t;
    typedef logic [PLAYER_W-1:0] player_bits_t;

    typedef enum logic [1:0] {
        RUN,
        PAUSED,
        STEP        // one frame released while paused
    } pause_state_t;

endpackage

// File: common/pointer_pkg.sv
package pointer_pkg;

    localparam int DELTA_W  = 9;
    localparam int POS_W    = 8;
    localparam int MBUT_W   = 3;
    localparam int PADDLE_W = 8;

    // paddle rests at mid travel
    localparam logic [PADDLE_W-1:0] PADDLE_MID = 8'd128;
    localparam logic [PADDLE_W-1:0] PADDLE_MAX = 8'd255;

    typedef logic signed [DELTA_W-1:0] mouse_delta_t;
    typedef logic [POS_W-1:0]          pos_t;        // pointer word is {y, x}
    typedef logic [MBUT_W-1:0]         mouse_but_t;
    typedef logic [PADDLE_W-1:0]       paddle_t;

endpackage

// File: common/input_ctrl_if.sv
interface input_ctrl_if;

    logic frame;        // one cycle at vs rising edge
    logic autofire;     // button 1 gate
    logic rot;
    logic flip;
    logic lock;

    modport ctrl (
        output frame,
        output autofire,
        output rot,
        output flip,
        output lock
    );

    modport dp (
        input frame,
        input autofire,
        input rot,
        input flip,
        input lock
    );

endinterface

// File: logic/joy_4way.sv
module joy_4way (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  en4way,
    input  input_pkg::board_joy_t joy_in,
    output input_pkg::board_joy_t joy_out
);
    import input_pkg::*;

    logic [DIR_W-1:0] dir;
    logic [DIR_W-1:0] last_single;
    logic             single;
    logic             multi;

    always_comb begin
        dir    = joy_in[DIR_W-1:0];
        // exactly one bit set when clearing the lowest one leaves nothing
        single = (dir != '0) && ((dir & (dir - 1'b1)) == '0);
        multi  = (dir != '0) && !single;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_single <= '0;
            joy_out     <= '0;
        end else begin
            if (single) begin
                last_single <= dir;
            end
            joy_out[BOARD_W-1:DIR_W] <= joy_in[BOARD_W-1:DIR_W];
            if (en4way && multi) begin
                joy_out[DIR_W-1:0] <= last_single;  // diagonal keeps old direction
            end else begin
                joy_out[DIR_W-1:0] <= dir;
            end
        end
    end

endmodule

// File: logic/player_map.sv
module player_map (
    input  logic                      clk,
    input  logic                      rst,
    input_ctrl_if.dp                  ctrl,
    input  input_pkg::board_joy_t     board1,
    input  input_pkg::board_joy_t     board2,
    input  input_pkg::game_joy_t      key_joy1,
    input  input_pkg::game_joy_t      key_joy2,
    input  input_pkg::player_bits_t   key_coin,
    input  input_pkg::player_bits_t   key_start,
    input  input_pkg::player_bits_t   board_coin,
    input  input_pkg::player_bits_t   board_start,
    input  pointer_pkg::mouse_but_t   mouse_but,
    output logic                      joy_pause,
    output input_pkg::game_joy_t      game_joy1,
    output input_pkg::game_joy_t      game_joy2,
    output input_pkg::player_bits_t   game_coin,
    output input_pkg::player_bits_t   game_start
);
    import input_pkg::*;

    game_joy_t    joy1_or;
    game_joy_t    joy2_or;
    player_bits_t joy_coin;
    player_bits_t joy_start;

    // autofire gate on button 1, then optional 90 degree turn
    function automatic game_joy_t map_joy(input game_joy_t j, input logic rot,
                                          input logic flip, input logic fire);
        game_joy_t o;
        o           = j;
        o[BUT1_BIT] = j[BUT1_BIT] & fire;
        if (rot) begin
            if (flip) begin
                o[DIR_UP]    = j[DIR_LEFT];
                o[DIR_DOWN]  = j[DIR_RIGHT];
                o[DIR_LEFT]  = j[DIR_DOWN];
                o[DIR_RIGHT] = j[DIR_UP];
            end else begin
                o[DIR_UP]    = j[DIR_RIGHT];
                o[DIR_DOWN]  = j[DIR_LEFT];
                o[DIR_LEFT]  = j[DIR_UP];
                o[DIR_RIGHT] = j[DIR_DOWN];
            end
        end
        return o ^ {JOY_W{ACTIVE_LOW}};
    endfunction

    always_comb begin
        joy1_or   = board1[JOY_W-1:0] | key_joy1 | (game_joy_t'(mouse_but) << BUT1_BIT);
        joy2_or   = board2[JOY_W-1:0] | key_joy2;
        joy_coin  = {2'b00, board2[COIN_BIT], board1[COIN_BIT]};
        joy_start = {2'b00, board2[START_BIT], board1[START_BIT]};
        joy_pause = board1[PAUSE_BIT] | board2[PAUSE_BIT];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            game_joy1  <= {JOY_W{ACTIVE_LOW}};
            game_joy2  <= {JOY_W{ACTIVE_LOW}};
            game_coin  <= {PLAYER_W{ACTIVE_LOW}};
            game_start <= {PLAYER_W{ACTIVE_LOW}};
        end else if (ctrl.lock) begin
            // locked core sees no player activity
            game_joy1  <= {JOY_W{ACTIVE_LOW}};
            game_joy2  <= {JOY_W{ACTIVE_LOW}};
            game_coin  <= {PLAYER_W{ACTIVE_LOW}};
            game_start <= {PLAYER_W{ACTIVE_LOW}};
        end else begin
            game_joy1  <= map_joy(joy1_or, ctrl.rot, ctrl.flip, ctrl.autofire);
            game_joy2  <= map_joy(joy2_or, ctrl.rot, ctrl.flip, ctrl.autofire);
            game_coin  <= {PLAYER_W{ACTIVE_LOW}} ^ (board_coin | key_coin | joy_coin);
            game_start <= {PLAYER_W{ACTIVE_LOW}} ^ (board_start | key_start | joy_start);
        end
    end

endmodule

// File: logic/input_ctrl.sv
module input_ctrl (
    input  logic       clk,
    input  logic       rst,
    input  logic       vs,
    input  logic       autofire_en,
    input  logic       dip_flip,
    input  logic       rot_control,
    input  logic       lock,
    input  logic       key_pause,
    input  logic       osd_pause,
    input  logic       key_reset,
    input  logic       key_service,
    input  logic       key_tilt,
    input  logic       joy_pause,
    input_ctrl_if.ctrl ctrl,
    output logic       soft_rst,
    output logic       game_pause,
    output logic       game_service,
    output logic       game_tilt
);
    import input_pkg::*;

    logic              vs_l;
    logic              key_pause_l;
    logic              joy_pause_l;
    logic              key_reset_l;
    logic              service_l;
    logic              osd_s;       // osd level, one stage in
    logic              osd_l;
    logic              vs_rise;
    logic              vs_fall;
    logic              pause_edge;
    logic              service_edge;
    logic              osd_change;
    logic [FIRE_W-1:0] fire_cnt;
    pause_state_t      state;
    pause_state_t      state_nx;

    always_comb begin
        vs_rise      = vs && !vs_l;
        vs_fall      = !vs && vs_l;
        pause_edge   = (key_pause && !key_pause_l) || (joy_pause && !joy_pause_l);
        service_edge = key_service && !service_l;
        osd_change   = osd_s ^ osd_l;
    end

    always_comb begin
        state_nx = state;
        case (state)
            RUN: begin
                if (pause_edge) state_nx = PAUSED;
            end
            PAUSED: begin
                if (pause_edge) begin
                    state_nx = RUN;
                end else if (service_edge) begin
                    state_nx = STEP;    // let one frame through
                end
            end
            STEP: begin
                if (pause_edge) begin
                    state_nx = RUN;
                end else if (vs_fall) begin
                    state_nx = PAUSED;
                end
            end
            default: state_nx = RUN;
        endcase
        // menu level wins over any toggle
        if (osd_change) begin
            state_nx = osd_s ? PAUSED : RUN;
        end
        if (lock) begin
            state_nx = RUN;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vs_l        <= 1'b0;
            key_pause_l <= 1'b0;
            joy_pause_l <= 1'b0;
            key_reset_l <= 1'b0;
            service_l   <= 1'b0;
            osd_s       <= 1'b0;
            osd_l       <= 1'b0;
        end else begin
            vs_l        <= vs;
            key_pause_l <= key_pause;
            joy_pause_l <= joy_pause;
            key_reset_l <= key_reset;
            service_l   <= key_service;
            osd_s       <= osd_pause;
            osd_l       <= osd_s;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fire_cnt      <= '0;
            ctrl.frame    <= 1'b0;
            ctrl.autofire <= 1'b1;
            ctrl.rot      <= 1'b0;
            ctrl.flip     <= 1'b0;
            ctrl.lock     <= 1'b0;
        end else begin
            if (vs_rise) begin
                fire_cnt <= fire_cnt + 1'b1;
            end
            ctrl.frame    <= vs_rise;
            ctrl.autofire <= !autofire_en || (fire_cnt >= AUTOFIRE_ON);
            ctrl.rot      <= rot_control;
            ctrl.flip     <= dip_flip;
            ctrl.lock     <= lock;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= RUN;
            game_pause   <= 1'b0;
            soft_rst     <= 1'b0;
            game_service <= ACTIVE_LOW;
            game_tilt    <= ACTIVE_LOW;
        end else begin
            state        <= state_nx;
            game_pause   <= (state_nx == PAUSED);
            soft_rst     <= key_reset && !key_reset_l;   // single pulse
            game_service <= lock ? ACTIVE_LOW : (key_service ^ ACTIVE_LOW);
            game_tilt    <= key_tilt ^ ACTIVE_LOW;
        end
    end

endmodule

// File: pointer/mouse_accum.sv
module mouse_accum (
    input  logic                      clk,
    input  logic                      rst,
    input_ctrl_if.dp                  ctrl,
    input  input_pkg::game_joy_t      joy2,
    input  pointer_pkg::mouse_delta_t mouse_dx,
    input  pointer_pkg::mouse_delta_t mouse_dy,
    input  logic [7:0]                mouse_f,
    input  logic                      mouse_st,
    output logic [15:0]               mouse_1p,
    output logic [15:0]               mouse_2p,
    output pointer_pkg::mouse_but_t   mouse_but
);
    import input_pkg::*;
    import pointer_pkg::*;

    pos_t x1;
    pos_t y1;
    pos_t x2;
    pos_t y2;
    pos_t x2_nx;
    pos_t y2_nx;

    // joy2 is active low, so a zero bit means pressed
    always_comb begin
        x2_nx = x2;
        y2_nx = y2;
        if (!joy2[DIR_RIGHT]) x2_nx = x2_nx + pos_t'(1);
        if (!joy2[DIR_LEFT])  x2_nx = x2_nx - pos_t'(1);
        if (!joy2[DIR_DOWN])  y2_nx = y2_nx + pos_t'(1);
        if (!joy2[DIR_UP])    y2_nx = y2_nx - pos_t'(1);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            x1        <= '0;
            y1        <= '0;
            x2        <= '0;
            y2        <= '0;
            mouse_but <= '0;
        end else begin
            if (mouse_st) begin
                mouse_but <= mouse_f[MBUT_W-1:0];
                if (!ctrl.lock) begin
                    x1 <= x1 + mouse_dx[POS_W-1:0];   // wraps
                    y1 <= y1 + mouse_dy[POS_W-1:0];
                end
            end
            if (ctrl.frame && !ctrl.lock) begin
                x2 <= x2_nx;
                y2 <= y2_nx;
            end
        end
    end

    assign mouse_1p = {y1, x1};
    assign mouse_2p = {y2, x2};

endmodule

// File: pointer/paddle_pos.sv
module paddle_pos (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mouse_st,
    input  pointer_pkg::mouse_delta_t mouse_dx,
    output pointer_pkg::paddle_t      paddle
);
    import pointer_pkg::*;

    logic signed [PADDLE_W+1:0] sum;   // room for sign and overflow

    always_comb begin
        sum = $signed({2'b00, paddle}) + $signed({mouse_dx[DELTA_W-1], mouse_dx});
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            paddle <= PADDLE_MID;
        end else if (mouse_st) begin
            if (sum[PADDLE_W+1]) begin
                paddle <= '0;               // below zero
            end else if (sum[PADDLE_W]) begin
                paddle <= PADDLE_MAX;
            end else begin
                paddle <= sum[PADDLE_W-1:0];
            end
        end
    end

endmodule

// File: logic/input_top.sv
module input_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      vs,
    input  logic                      dip_flip,
    input  logic                      autofire_en,
    input  logic                      en4way,
    input  logic                      rot_control,
    input  logic                      lock,
    output logic                      soft_rst,
    output logic                      game_pause,

    input  input_pkg::board_joy_t     board_joy1,
    input  input_pkg::board_joy_t     board_joy2,
    input  input_pkg::player_bits_t   board_coin,
    input  input_pkg::player_bits_t   board_start,

    input  input_pkg::game_joy_t      key_joy1,
    input  input_pkg::game_joy_t      key_joy2,
    input  input_pkg::player_bits_t   key_start,
    input  input_pkg::player_bits_t   key_coin,
    input  logic                      key_service,
    input  logic                      key_tilt,
    input  logic                      key_pause,
    input  logic                      osd_pause,
    input  logic                      key_reset,

    output input_pkg::game_joy_t      game_joy1,
    output input_pkg::game_joy_t      game_joy2,
    output input_pkg::player_bits_t   game_coin,
    output input_pkg::player_bits_t   game_start,
    output logic                      game_service,
    output logic                      game_tilt,

    input  pointer_pkg::mouse_delta_t bd_mouse_dx,
    input  pointer_pkg::mouse_delta_t bd_mouse_dy,
    input  logic [7:0]                bd_mouse_f,
    input  logic                      bd_mouse_st,
    output logic [15:0]               mouse_1p,
    output logic [15:0]               mouse_2p,
    output pointer_pkg::paddle_t      paddle
);
    import input_pkg::*;
    import pointer_pkg::*;

    board_joy_t joy1_4w;
    board_joy_t joy2_4w;
    logic       joy_pause;
    mouse_but_t mouse_but;

    input_ctrl_if u_ctrl_if ();

    input_ctrl u_input_ctrl (
        .clk          (clk),
        .rst          (rst),
        .vs           (vs),
        .autofire_en  (autofire_en),
        .dip_flip     (dip_flip),
        .rot_control  (rot_control),
        .lock         (lock),
        .key_pause    (key_pause),
        .osd_pause    (osd_pause),
        .key_reset    (key_reset),
        .key_service  (key_service),
        .key_tilt     (key_tilt),
        .joy_pause    (joy_pause),
        .ctrl         (u_ctrl_if.ctrl),
        .soft_rst     (soft_rst),
        .game_pause   (game_pause),
        .game_service (game_service),
        .game_tilt    (game_tilt)
    );

    joy_4way u_4way_1p (
        .clk     (clk),
        .rst     (rst),
        .en4way  (en4way),
        .joy_in  (board_joy1),
        .joy_out (joy1_4w)
    );

    joy_4way u_4way_2p (
        .clk     (clk),
        .rst     (rst),
        .en4way  (en4way),
        .joy_in  (board_joy2),
        .joy_out (joy2_4w)
    );

    player_map u_player_map (
        .clk         (clk),
        .rst         (rst),
        .ctrl        (u_ctrl_if.dp),
        .board1      (joy1_4w),
        .board2      (joy2_4w),
        .key_joy1    (key_joy1),
        .key_joy2    (key_joy2),
        .key_coin    (key_coin),
        .key_start   (key_start),
        .board_coin  (board_coin),
        .board_start (board_start),
        .mouse_but   (mouse_but),
        .joy_pause   (joy_pause),
        .game_joy1   (game_joy1),
        .game_joy2   (game_joy2),
        .game_coin   (game_coin),
        .game_start  (game_start)
    );

    // 2p pointer follows the game-side joystick 2
    mouse_accum u_mouse_accum (
        .clk       (clk),
        .rst       (rst),
        .ctrl      (u_ctrl_if.dp),
        .joy2      (game_joy2),
        .mouse_dx  (bd_mouse_dx),
        .mouse_dy  (bd_mouse_dy),
        .mouse_f   (bd_mouse_f),
        .mouse_st  (bd_mouse_st),
        .mouse_1p  (mouse_1p),
        .mouse_2p  (mouse_2p),
        .mouse_but (mouse_but)
    );

    paddle_pos u_paddle_pos (
        .clk      (clk),
        .rst      (rst),
        .mouse_st (bd_mouse_st),
        .mouse_dx (bd_mouse_dx),
        .paddle   (paddle)
    );

endmodule

// File: test/input_chk.sv
module input_chk (
    input logic clk,
    input logic rst,
    input logic lock,
    input logic autofire_en,
    input logic autofire,
    input logic soft_rst,
    input logic game_pause
);

    // soft reset is a single-cycle pulse
    soft_rst_pulse: assert property (@(posedge clk) disable iff (rst) soft_rst |=> !soft_rst)
        else $error("soft_rst high for two cycles in a row");

    lock_no_pause: assert property (@(posedge clk) disable iff (rst) lock |=> !game_pause)
        else $error("game_pause high while lock is set");

    // gate stays open with autofire off
    autofire_open: assert property (@(posedge clk) disable iff (rst) !autofire_en |=> autofire)
        else $error("autofire gate closed while autofire_en is low");

endmodule

bind input_ctrl input_chk u_input_chk (
    .clk         (clk),
    .rst         (rst),
    .lock        (lock),
    .autofire_en (autofire_en),
    .autofire    (ctrl.autofire),
    .soft_rst    (soft_rst),
    .game_pause  (game_pause)
);

// File: test/tb_input_top.sv
module tb_input_top;
    import input_pkg::*;
    import pointer_pkg::*;

    localparam int CLK_PERIOD = 20;
    // cycles per test, doubled for margin
    localparam int TEST_CYCLES   = 10 + 40 + 10 + 80 + 30 + 70;
    localparam int WATCHDOG_TIME = 2 * TEST_CYCLES * CLK_PERIOD;

    logic         clk;
    logic         rst;
    logic         vs;
    logic         dip_flip;
    logic         autofire_en;
    logic         en4way;
    logic         rot_control;
    logic         lock;
    logic         soft_rst;
    logic         game_pause;
    board_joy_t   board_joy1;
    board_joy_t   board_joy2;
    player_bits_t board_coin;
    player_bits_t board_start;
    game_joy_t    key_joy1;
    game_joy_t    key_joy2;
    player_bits_t key_start;
    player_bits_t key_coin;
    logic         key_service;
    logic         key_tilt;
    logic         key_pause;
    logic         osd_pause;
    logic         key_reset;
    game_joy_t    game_joy1;
    game_joy_t    game_joy2;
    player_bits_t game_coin;
    player_bits_t game_start;
    logic         game_service;
    logic         game_tilt;
    mouse_delta_t bd_mouse_dx;
    mouse_delta_t bd_mouse_dy;
    logic [7:0]   bd_mouse_f;
    logic         bd_mouse_st;
    logic [15:0]  mouse_1p;
    logic [15:0]  mouse_2p;
    paddle_t      paddle;

    logic [31:0]  seed;
    logic [2:0]   mbut_exp;     // last latched mouse buttons
    int           errors;
    int           tests;
    int           tests_failed;

    input_top u_input_top (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] next_random();
        seed = xorshift(seed);
        return seed;
    endfunction

    // expected game word from the merged active-high bits
    function automatic game_joy_t joy_expect(input game_joy_t m, input logic rot, input logic flip);
        game_joy_t t;
        t = m;
        if (rot && !flip) begin
            t[3] = m[0];
            t[2] = m[1];
            t[1] = m[3];
            t[0] = m[2];
        end else if (rot) begin
            t[3] = m[1];    // flipped turn
            t[2] = m[0];
            t[1] = m[2];
            t[0] = m[3];
        end
        return ~t;
    endfunction

    function automatic paddle_t paddle_step(input paddle_t p, input logic [8:0] dx);
        int s;
        s = int'(p) + int'($signed(dx));
        if (s < 0) s = 0;
        if (s > 255) s = 255;
        return paddle_t'(s);
    endfunction

    task automatic mismatch(input string sig, input logic [31:0] got, input logic [31:0] exp);
        $display("ERROR at %0t: %s = 0x%0h, expected 0x%0h", $time, sig, got, exp);
        errors++;
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    task automatic idle_inputs();
        board_joy1  = '0;
        board_joy2  = '0;
        board_coin  = '0;
        board_start = '0;
        key_joy1    = '0;
        key_joy2    = '0;
        key_coin    = '0;
        key_start   = '0;
    endtask

    // one vs period, ends on a falling clock edge
    task automatic vs_frame();
        vs = 1'b1;
        repeat (2) @(negedge clk);
        vs = 1'b0;
        repeat (4) @(negedge clk);
    endtask

    task automatic toggle_pause(input logic exp);
        key_pause = 1'b1;
        @(negedge clk);
        if (game_pause !== exp) mismatch("game_pause", 32'(game_pause), 32'(exp));
        key_pause = 1'b0;
        @(negedge clk);
    endtask

    task automatic reset_values();
        int e0;
        e0 = errors;
        if (soft_rst !== 1'b0) mismatch("soft_rst", 32'(soft_rst), 32'd0);
        if (game_pause !== 1'b0) mismatch("game_pause", 32'(game_pause), 32'd0);
        if (game_service !== 1'b1) mismatch("game_service", 32'(game_service), 32'd1);
        if (game_tilt !== 1'b1) mismatch("game_tilt", 32'(game_tilt), 32'd1);
        if (game_joy1 !== 10'h3ff) mismatch("game_joy1", 32'(game_joy1), 32'h3ff);
        if (game_joy2 !== 10'h3ff) mismatch("game_joy2", 32'(game_joy2), 32'h3ff);
        if (game_coin !== 4'hf) mismatch("game_coin", 32'(game_coin), 32'hf);
        if (game_start !== 4'hf) mismatch("game_start", 32'(game_start), 32'hf);
        if (mouse_1p !== 16'h0) mismatch("mouse_1p", 32'(mouse_1p), 32'h0);
        if (mouse_2p !== 16'h0) mismatch("mouse_2p", 32'(mouse_2p), 32'h0);
        if (paddle !== 8'd128) mismatch("paddle", 32'(paddle), 32'd128);
        if (u_input_top.u_ctrl_if.autofire !== 1'b1) begin
            mismatch("autofire", 32'(u_input_top.u_ctrl_if.autofire), 32'd1);
        end
        report_test("reset values", e0);
    endtask

    task automatic merge_and_lock();
        int           e0;
        logic [31:0]  r;
        game_joy_t    m1;
        game_joy_t    m2;
        player_bits_t c_exp;
        player_bits_t s_exp;
        e0 = errors;
        for (int i = 0; i < 12; i++) begin
            r = next_random();
            board_joy1  = r[15:0] & 16'hfeff;   // board pause bits stay clear
            board_joy2  = r[31:16] & 16'hfeff;
            r = next_random();
            key_joy1    = r[9:0];
            key_joy2    = r[19:10];
            key_coin    = r[23:20];
            key_start   = r[27:24];
            r = next_random();
            board_coin  = r[3:0];
            board_start = r[7:4];
            rot_control = (i % 3) != 0;
            dip_flip    = (i % 3) == 2;
            repeat (2) @(negedge clk);
            m1    = board_joy1[9:0] | key_joy1 | {3'b000, mbut_exp, 4'b0000};
            m2    = board_joy2[9:0] | key_joy2;
            c_exp = ~(board_coin | key_coin | {2'b00, board_joy2[7], board_joy1[7]});
            s_exp = ~(board_start | key_start | {2'b00, board_joy2[6], board_joy1[6]});
            m1    = joy_expect(m1, rot_control, dip_flip);
            m2    = joy_expect(m2, rot_control, dip_flip);
            if (game_joy1 !== m1) mismatch("game_joy1", 32'(game_joy1), 32'(m1));
            if (game_joy2 !== m2) mismatch("game_joy2", 32'(game_joy2), 32'(m2));
            if (game_coin !== c_exp) mismatch("game_coin", 32'(game_coin), 32'(c_exp));
            if (game_start !== s_exp) mismatch("game_start", 32'(game_start), 32'(s_exp));
        end
        lock        = 1'b1;
        key_service = 1'b1;
        key_tilt    = 1'b1;     // tilt is not locked
        repeat (2) @(negedge clk);
        if (game_joy1 !== 10'h3ff) mismatch("game_joy1", 32'(game_joy1), 32'h3ff);
        if (game_joy2 !== 10'h3ff) mismatch("game_joy2", 32'(game_joy2), 32'h3ff);
        if (game_coin !== 4'hf) mismatch("game_coin", 32'(game_coin), 32'hf);
        if (game_start !== 4'hf) mismatch("game_start", 32'(game_start), 32'hf);
        if (game_service !== 1'b1) mismatch("game_service", 32'(game_service), 32'd1);
        if (game_pause !== 1'b0) mismatch("game_pause", 32'(game_pause), 32'd0);
        if (game_tilt !== 1'b0) mismatch("game_tilt", 32'(game_tilt), 32'd0);
        lock        = 1'b0;
        key_service = 1'b0;
        key_tilt    = 1'b0;
        rot_control = 1'b0;
        dip_flip    = 1'b0;
        idle_inputs();
        repeat (2) @(negedge clk);
        report_test("merge, rotation and lock", e0);
    endtask

    task automatic four_way_filter();
        int e0;
        e0 = errors;
        en4way     = 1'b1;
        board_joy1 = 16'h0001;      // right
        repeat (2) @(negedge clk);
        if (game_joy1[3:0] !== 4'b1110) mismatch("game_joy1[3:0]", 32'(game_joy1[3:0]), 32'he);
        board_joy1 = 16'h0009;      // right and up
        repeat (2) @(negedge clk);
        if (game_joy1[3:0] !== 4'b1110) mismatch("game_joy1[3:0]", 32'(game_joy1[3:0]), 32'he);
        board_joy1 = 16'h0008;
        repeat (2) @(negedge clk);
        if (game_joy1[3:0] !== 4'b0111) mismatch("game_joy1[3:0]", 32'(game_joy1[3:0]), 32'h7);
        en4way     = 1'b0;
        board_joy1 = '0;
        repeat (2) @(negedge clk);
        report_test("4-way filter", e0);
    endtask

    task automatic autofire_and_pause();
        int e0;
        int active;
        e0     = errors;
        active = 0;
        autofire_en = 1'b1;
        key_joy1    = 10'h010;      // button 1 held
        repeat (8) begin
            vs_frame();
            if (game_joy1[4] == 1'b0) active++;
        end
        if (active != 2) mismatch("button 1 active frames", 32'(active), 32'd2);
        autofire_en = 1'b0;
        key_joy1    = '0;
        toggle_pause(1'b1);
        toggle_pause(1'b0);
        toggle_pause(1'b1);
        osd_pause = 1'b1;
        @(negedge clk);
        key_pause = 1'b1;           // toggle alone would resume here
        @(negedge clk);
        if (game_pause !== 1'b1) mismatch("game_pause", 32'(game_pause), 32'd1);
        key_pause = 1'b0;
        osd_pause = 1'b0;
        repeat (2) @(negedge clk);
        if (game_pause !== 1'b0) mismatch("game_pause", 32'(game_pause), 32'd0);
        key_reset = 1'b1;
        @(negedge clk);
        if (soft_rst !== 1'b1) mismatch("soft_rst", 32'(soft_rst), 32'd1);
        @(negedge clk);
        if (soft_rst !== 1'b0) mismatch("soft_rst", 32'(soft_rst), 32'd0);
        key_reset = 1'b0;
        @(negedge clk);
        report_test("autofire and pause", e0);
    endtask

    task automatic frame_step();
        int e0;
        int n;
        e0 = errors;
        n  = 0;
        toggle_pause(1'b1);
        key_service = 1'b1;
        @(negedge clk);
        if (game_pause !== 1'b0) mismatch("game_pause", 32'(game_pause), 32'd0);
        if (game_service !== 1'b0) mismatch("game_service", 32'(game_service), 32'd0);
        key_service = 1'b0;
        @(negedge clk);
        if (game_service !== 1'b1) mismatch("game_service", 32'(game_service), 32'd1);
        vs = 1'b1;
        repeat (3) @(negedge clk);
        if (game_pause !== 1'b0) mismatch("game_pause", 32'(game_pause), 32'd0);
        vs = 1'b0;
        while (game_pause !== 1'b1 && n < 8) begin
            @(negedge clk);
            n++;
        end
        if (game_pause !== 1'b1) begin
            $display("game_pause did not return high after the falling edge of vs");
            errors++;
        end
        toggle_pause(1'b0);
        report_test("frame step", e0);
    endtask

    task automatic pointer_moves();
        int          e0;
        logic [31:0] r;
        pos_t        x1;
        pos_t        y1;
        pos_t        x2;
        paddle_t     pad;
        e0  = errors;
        x1  = '0;
        y1  = '0;
        x2  = '0;
        pad = 8'd128;
        if (mouse_1p !== 16'h0) mismatch("mouse_1p", 32'(mouse_1p), 32'h0);
        if (paddle !== pad) mismatch("paddle", 32'(paddle), 32'(pad));
        for (int i = 0; i < 10; i++) begin
            r = next_random();
            bd_mouse_dx = r[8:0];
            bd_mouse_dy = r[17:9];
            bd_mouse_f  = r[25:18];
            bd_mouse_st = 1'b1;
            x1       = x1 + r[7:0];     // positions wrap
            y1       = y1 + r[16:9];
            pad      = paddle_step(pad, r[8:0]);
            mbut_exp = r[20:18];
            @(negedge clk);
            bd_mouse_st = 1'b0;
            if (mouse_1p !== {y1, x1}) mismatch("mouse_1p", 32'(mouse_1p), 32'({y1, x1}));
            if (paddle !== pad) mismatch("paddle", 32'(paddle), 32'(pad));
            @(negedge clk);
            if (game_joy1[6:4] !== ~mbut_exp) begin
                mismatch("game_joy1[6:4]", 32'(game_joy1[6:4]), 32'(~mbut_exp));
            end
        end
        key_joy2 = 10'h002;         // left on player 2
        if (mouse_2p !== 16'h0) mismatch("mouse_2p", 32'(mouse_2p), 32'h0);
        repeat (3) begin
            vs_frame();
            x2 = x2 - 8'd1;
            if (mouse_2p !== {8'h00, x2}) mismatch("mouse_2p", 32'(mouse_2p), 32'({8'h00, x2}));
        end
        lock       = 1'b1;
        bd_mouse_f = '0;
        repeat (2) @(negedge clk);
        bd_mouse_dx = 9'sd5;
        bd_mouse_dy = 9'sd3;
        bd_mouse_st = 1'b1;
        pad      = paddle_step(pad, 9'd5);  // paddle ignores lock
        mbut_exp = 3'b000;
        @(negedge clk);
        bd_mouse_st = 1'b0;
        if (mouse_1p !== {y1, x1}) mismatch("mouse_1p", 32'(mouse_1p), 32'({y1, x1}));
        if (paddle !== pad) mismatch("paddle", 32'(paddle), 32'(pad));
        vs_frame();
        if (mouse_2p !== {8'h00, x2}) mismatch("mouse_2p", 32'(mouse_2p), 32'({8'h00, x2}));
        lock     = 1'b0;
        key_joy2 = '0;
        repeat (2) @(negedge clk);
        report_test("pointer", e0);
    endtask

    initial begin
        rst          = 1'b1;
        vs           = 1'b0;
        dip_flip     = 1'b0;
        autofire_en  = 1'b0;
        en4way       = 1'b0;
        rot_control  = 1'b0;
        lock         = 1'b0;
        key_service  = 1'b0;
        key_tilt     = 1'b0;
        key_pause    = 1'b0;
        osd_pause    = 1'b0;
        key_reset    = 1'b0;
        bd_mouse_dx  = '0;
        bd_mouse_dy  = '0;
        bd_mouse_f   = '0;
        bd_mouse_st  = 1'b0;
        idle_inputs();
        seed         = 32'hbf6c_944e;
        mbut_exp     = 3'b000;
        errors       = 0;
        tests        = 0;
        tests_failed = 0;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        reset_values();
        merge_and_lock();
        four_way_filter();
        autofire_and_pause();
        frame_step();
        pointer_moves();
        $display("tests run %0d, failed %0d, errors %0d", tests, tests_failed, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_TIME);
        $display("watchdog expired before the tests finished");
        $display("Something failed");
        $finish;
    end

endmodule

// File: verilog.f
common/input_pkg.sv
common/pointer_pkg.sv
common/input_ctrl_if.sv
logic/joy_4way.sv
logic/player_map.sv
logic/input_ctrl.sv
pointer/mouse_accum.sv
pointer/paddle_pos.sv
logic/input_top.sv
test/input_chk.sv
test/tb_input_top.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_input_top -f verilog.f \
    || { echo "build failed"; exit 1; }

out="$(./obj_dir/Vtb_input_top 2>&1)"
echo "$out"

echo "$out" | grep -qx "Everything OK" && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
